//--- Makefile
.PHONY: all lint clean

all: obj_dir/Vtb_ppu_timing
	@out="$$(./obj_dir/Vtb_ppu_timing)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

obj_dir/Vtb_ppu_timing: project.f hw/*.sv testbench/tb_ppu_timing.sv
	verilator --binary --timing -Wno-fatal -j 0 --top-module tb_ppu_timing -f project.f

lint:
	verilator --lint-only -Wall --timing --top-module ppu_timing_top -f project.f

clean:
	rm -rf obj_dir

//--- hw/h_decoder.sv
// Combinational decode plane that turns the dot count into the horizontal event bits
module h_decoder import ppu_timing_pkg::*; (
	input  h_pos_t    h_cnt,
	input  v_pos_t    v_cnt,
	input  logic      odd_frame,
	output h_decode_t hdec
);

	logic [2:0] phase;	// Position inside an 8-dot tile slot
	logic       vis_fetch;
	logic       pre_fetch;
	logic       prerender;

	assign phase     = h_cnt[2:0];
	assign vis_fetch = (h_cnt >= 9'd1) && (h_cnt <= eev_dot);
	assign pre_fetch = (h_cnt >= burst_clr_dot) && (h_cnt <= prefetch_end);	// First two tiles
	assign prerender = (v_cnt == prerender_line);

	// Tile fetch window and its four phases
	assign hdec[hd_fetch_win] = vis_fetch | pre_fetch;
	assign hdec[hd_nt]        = (phase == 3'd1);
	assign hdec[hd_at]        = (phase == 3'd3);
	assign hdec[hd_ta]        = (phase == 3'd5);
	assign hdec[hd_tb]        = (phase == 3'd7);

	// Sprite evaluation bounds
	assign hdec[hd_sev] = (h_cnt == sev_dot);
	assign hdec[hd_eev] = (h_cnt == eev_dot);

	assign hdec[hd_clip] = (h_cnt >= 9'd1) && (h_cnt <= clip_dots);

	// Blanking range, held by a flop downstream
	assign hdec[hd_hb_set] = (h_cnt == hb_set_dot);
	assign hdec[hd_hb_clr] = (h_cnt == 9'd1);

	assign hdec[hd_sync_set]  = (h_cnt == sync_set_dot);
	assign hdec[hd_sync_clr]  = (h_cnt == sync_clr_dot);
	assign hdec[hd_burst_set] = (h_cnt == burst_set_dot);
	assign hdec[hd_burst_clr] = (h_cnt == burst_clr_dot);

	// Line wrap points
	assign hdec[hd_last] = (h_cnt == h_total - 1);
	assign hdec[hd_skip] = odd_frame & prerender & (h_cnt == h_total - 2);

endmodule

//--- hw/h_pos_logic.sv
// Horizontal event flops: registered fetch, sprite and clip strobes, blank, sync and burst ranges
module h_pos_logic import ppu_timing_pkg::*; (
	input  logic      pclk,
	input  logic      rst_n,
	input  h_pos_t    h_cnt,
	input  v_pos_t    v_cnt,
	input  h_decode_t hdec,
	input  logic      render_en,
	input  logic      bg_clip,
	input  logic      obj_clip,
	input  logic      vsync,
	input  logic      picture,	// Aligned with reported line
	output h_pos_t    h_pos,
	output v_pos_t    v_pos,
	output logic      fetch_nt,
	output logic      fetch_at,
	output logic      fetch_ta,
	output logic      fetch_tb,
	output logic      s_ev,
	output logic      e_ev,
	output logic      clip_b,
	output logic      clip_o,
	output logic      hblank,
	output logic      hblank_start,
	output logic      sync,
	output logic      burst,
	output logic      sc_cnt
);

	logic fetch_ok;
	logic sev_ok;
	logic hsync_q;	// Horizontal part of sync
	logic burst_q;

	// Dot 0 never fetches, so picture is already valid for the counted line
	assign fetch_ok = render_en & hdec[hd_fetch_win] & (picture | (v_cnt == prerender_line));
	assign sev_ok   = render_en & picture;

	// Reported position, one cycle behind the counters
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			h_pos <= '0;
			v_pos <= '0;
		end else begin
			h_pos <= h_cnt;
			v_pos <= v_cnt;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_nt     <= 1'b0;
			fetch_at     <= 1'b0;
			fetch_ta     <= 1'b0;
			fetch_tb     <= 1'b0;
			s_ev         <= 1'b0;
			e_ev         <= 1'b0;
			clip_b       <= 1'b0;
			clip_o       <= 1'b0;
			hblank_start <= 1'b0;
		end else begin
			fetch_nt     <= fetch_ok & hdec[hd_nt];
			fetch_at     <= fetch_ok & hdec[hd_at];
			fetch_ta     <= fetch_ok & hdec[hd_ta];
			fetch_tb     <= fetch_ok & hdec[hd_tb];
			s_ev         <= sev_ok & hdec[hd_sev];
			e_ev         <= sev_ok & hdec[hd_eev];
			clip_b       <= bg_clip & hdec[hd_clip];
			clip_o       <= obj_clip & hdec[hd_clip];
			hblank_start <= hdec[hd_last] | (hdec[hd_skip] & render_en);	// Counter now at dot 0
		end
	end

	// Set/clear range flops, set wins
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			hblank  <= 1'b1;	// Reset position is dot 0
			hsync_q <= 1'b0;
			burst_q <= 1'b0;
		end else begin
			if (hdec[hd_hb_set]) begin
				hblank <= 1'b1;
			end else if (hdec[hd_hb_clr]) begin
				hblank <= 1'b0;
			end
			if (hdec[hd_sync_set]) begin
				hsync_q <= 1'b1;
			end else if (hdec[hd_sync_clr]) begin
				hsync_q <= 1'b0;
			end
			if (hdec[hd_burst_set]) begin
				burst_q <= 1'b1;
			end else if (hdec[hd_burst_clr]) begin
				burst_q <= 1'b0;
			end
		end
	end

	assign sync   = hsync_q | vsync;	// Whole line during vsync
	assign burst  = burst_q & ~vsync;
	assign sc_cnt = hblank & render_en;

endmodule

//--- hw/hv_counters.sv
// Dot and line counters of the timing generator, with line and frame wrap and the odd-frame dot skip
module hv_counters import ppu_timing_pkg::*; (
	input  logic   pclk,
	input  logic   rst_n,
	input  logic   render_en,
	input  logic   hd_last,	// Dot 340 decoded
	input  logic   hd_skip,	// Dot 339 of pre-render line, odd frame
	input  logic   vd_last,	// Pre-render line decoded
	output h_pos_t h_cnt,
	output v_pos_t v_cnt,
	output logic   odd_frame
);

	logic line_end;
	logic frame_end;

	// Short line only while rendering
	assign line_end  = hd_last | (hd_skip & render_en);
	assign frame_end = line_end & vd_last;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			v_cnt <= '0;
		end else if (frame_end) begin
			v_cnt <= '0;
		end else if (line_end) begin
			v_cnt <= v_cnt + 9'd1;
		end
	end

	// Frame parity, flips once per frame
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			odd_frame <= 1'b0;
		end else if (frame_end) begin
			odd_frame <= ~odd_frame;
		end
	end

endmodule

//--- hw/ppu_timing_pkg.sv
// Frame geometry, event positions and decode vector layouts, imported by the timing RTL and testbench
package ppu_timing_pkg;

	localparam int h_total        = 341;	// Dots per line
	localparam int v_total        = 262;	// Lines per frame
	localparam int vis_lines      = 240;
	localparam int vblank_line    = 241;	// Blank flag set line
	localparam int prerender_line = 261;

	// Horizontal event positions as counter values
	localparam int sev_dot        = 65;
	localparam int eev_dot        = 256;	// Also last visible fetch dot
	localparam int hb_set_dot     = 257;
	localparam int sync_set_dot   = 277;
	localparam int sync_clr_dot   = 302;
	localparam int burst_set_dot  = 306;
	localparam int burst_clr_dot  = 321;	// Also first prefetch dot
	localparam int prefetch_end   = 336;
	localparam int clip_dots      = 8;	// Left edge clip width

	localparam int vsync_set_line = 244;
	localparam int vsync_clr_line = 247;

	typedef logic [8:0]  h_pos_t;
	typedef logic [8:0]  v_pos_t;
	typedef logic [15:0] h_decode_t;
	typedef logic [7:0]  v_decode_t;

	localparam int hd_fetch_win = 0;
	localparam int hd_nt        = 1;
	localparam int hd_at        = 2;
	localparam int hd_ta        = 3;
	localparam int hd_tb        = 4;
	localparam int hd_sev       = 5;
	localparam int hd_eev       = 6;
	localparam int hd_clip      = 7;
	localparam int hd_hb_set    = 8;
	localparam int hd_hb_clr    = 9;
	localparam int hd_sync_set  = 10;
	localparam int hd_sync_clr  = 11;
	localparam int hd_burst_set = 12;
	localparam int hd_burst_clr = 13;
	localparam int hd_last      = 14;
	localparam int hd_skip      = 15;

	localparam int vd_pic_set   = 0;
	localparam int vd_pic_clr   = 1;
	localparam int vd_vset      = 2;
	localparam int vd_vclr      = 3;
	localparam int vd_vsync_set = 4;
	localparam int vd_vsync_clr = 5;
	localparam int vd_last      = 6;

endpackage

//--- hw/ppu_timing_top.sv
// Top of the video timing subsystem, connects counters, decoders, range logic and the vblank flag
module ppu_timing_top import ppu_timing_pkg::*; (
	input  logic   pclk,
	input  logic   rst_n,
	input  logic   render_en,
	input  logic   vbl_en,
	input  logic   bg_clip,
	input  logic   obj_clip,
	input  logic   status_rd,
	output h_pos_t h_pos,
	output v_pos_t v_pos,
	output logic   fetch_nt,
	output logic   fetch_at,
	output logic   fetch_ta,
	output logic   fetch_tb,
	output logic   s_ev,
	output logic   e_ev,
	output logic   clip_b,
	output logic   clip_o,
	output logic   hblank,
	output logic   hblank_start,
	output logic   sync,
	output logic   burst,
	output logic   sc_cnt,
	output logic   picture,
	output logic   vblank,
	output logic   vsync,
	output logic   blnk,
	output logic   vset,
	output logic   vclr,
	output logic   irq,
	output logic   status_d7
);

	h_pos_t    h_cnt;
	v_pos_t    v_cnt;
	logic      odd_frame;
	h_decode_t hdec;
	v_decode_t vdec;

	hv_counters u_counters (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.render_en (render_en),
		.hd_last   (hdec[hd_last]),
		.hd_skip   (hdec[hd_skip]),
		.vd_last   (vdec[vd_last]),
		.h_cnt     (h_cnt),
		.v_cnt     (v_cnt),
		.odd_frame (odd_frame)
	);

	h_decoder u_h_decoder (
		.h_cnt     (h_cnt),
		.v_cnt     (v_cnt),
		.odd_frame (odd_frame),
		.hdec      (hdec)
	);

	v_decoder u_v_decoder (
		.v_cnt (v_cnt),
		.vdec  (vdec)
	);

	h_pos_logic u_h_pos (
		.pclk         (pclk),
		.rst_n        (rst_n),
		.h_cnt        (h_cnt),
		.v_cnt        (v_cnt),
		.hdec         (hdec),
		.render_en    (render_en),
		.bg_clip      (bg_clip),
		.obj_clip     (obj_clip),
		.vsync        (vsync),
		.picture      (picture),
		.h_pos        (h_pos),
		.v_pos        (v_pos),
		.fetch_nt     (fetch_nt),
		.fetch_at     (fetch_at),
		.fetch_ta     (fetch_ta),
		.fetch_tb     (fetch_tb),
		.s_ev         (s_ev),
		.e_ev         (e_ev),
		.clip_b       (clip_b),
		.clip_o       (clip_o),
		.hblank       (hblank),
		.hblank_start (hblank_start),
		.sync         (sync),
		.burst        (burst),
		.sc_cnt       (sc_cnt)
	);

	v_pos_logic u_v_pos (
		.pclk         (pclk),
		.rst_n        (rst_n),
		.vdec         (vdec),
		.hblank_start (hblank_start),
		.render_en    (render_en),
		.picture      (picture),
		.vblank       (vblank),
		.vsync        (vsync),
		.blnk         (blnk),
		.vset         (vset),
		.vclr         (vclr)
	);

	vblank_int u_vblank_int (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.vset      (vset),
		.vclr      (vclr),
		.vbl_en    (vbl_en),
		.status_rd (status_rd),
		.irq       (irq),
		.status_d7 (status_d7)
	);

endmodule

//--- hw/v_decoder.sv
// Combinational decode of the line count into the vertical event bits of the timing generator
module v_decoder import ppu_timing_pkg::*; (
	input  v_pos_t    v_cnt,
	output v_decode_t vdec
);

	always_comb begin
		vdec = '0;	// Top bit is spare

		// Picture range, lines 0 to 239
		vdec[vd_pic_set] = (v_cnt == 9'd0);
		vdec[vd_pic_clr] = (v_cnt == vis_lines);

		// Vertical blank opens after the idle line
		vdec[vd_vset] = (v_cnt == vblank_line);
		vdec[vd_vclr] = (v_cnt == prerender_line);

		vdec[vd_vsync_set] = (v_cnt == vsync_set_line);
		vdec[vd_vsync_clr] = (v_cnt == vsync_clr_line);	// First line after sync

		vdec[vd_last] = (v_cnt == v_total - 1);
	end

endmodule

//--- hw/v_pos_logic.sv
// Vertical range flops updated at each line start, plus vblank set and clear pulses and blanking
module v_pos_logic import ppu_timing_pkg::*; (
	input  logic      pclk,
	input  logic      rst_n,
	input  v_decode_t vdec,
	input  logic      hblank_start,	// Counter sits on dot 0
	input  logic      render_en,
	output logic      picture,
	output logic      vblank,
	output logic      vsync,
	output logic      blnk,
	output logic      vset,
	output logic      vclr
);

	// Edges seen once per line
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			vset <= 1'b0;
			vclr <= 1'b0;
		end else begin
			vset <= hblank_start & vdec[vd_vset];
			vclr <= hblank_start & vdec[vd_vclr];
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			picture <= 1'b1;	// Counters restart on line 0
			vblank  <= 1'b0;
			vsync   <= 1'b0;
		end else if (hblank_start) begin
			if (vdec[vd_pic_set]) begin
				picture <= 1'b1;
			end else if (vdec[vd_pic_clr]) begin
				picture <= 1'b0;
			end
			if (vdec[vd_vset]) begin
				vblank <= 1'b1;
			end else if (vdec[vd_vclr]) begin
				vblank <= 1'b0;
			end
			if (vdec[vd_vsync_set]) begin
				vsync <= 1'b1;
			end else if (vdec[vd_vsync_clr]) begin
				vsync <= 1'b0;
			end
		end
	end

	assign blnk = ~render_en | vblank;	// Forced blank when not rendering

endmodule

//--- hw/vblank_int.sv
// Vertical-blank status flag with read clear, sampled status bit and gated interrupt request
module vblank_int (
	input  logic pclk,
	input  logic rst_n,
	input  logic vset,
	input  logic vclr,
	input  logic vbl_en,	// Interrupt enable
	input  logic status_rd,
	output logic irq,
	output logic status_d7
);

	logic vbl_flag;

	// Set beats a read in the same cycle
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			vbl_flag <= 1'b0;
		end else if (vset) begin
			vbl_flag <= 1'b1;
		end else if (vclr || status_rd) begin
			vbl_flag <= 1'b0;
		end
	end

	// Value the CPU sees on the last read
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			status_d7 <= 1'b0;
		end else if (status_rd) begin
			status_d7 <= vbl_flag;
		end
	end

	assign irq = vbl_flag & vbl_en;

endmodule

//--- project.f
hw/ppu_timing_pkg.sv
hw/hv_counters.sv
hw/h_decoder.sv
hw/v_decoder.sv
hw/h_pos_logic.sv
hw/v_pos_logic.sv
hw/vblank_int.sv
hw/ppu_timing_top.sv
testbench/tb_ppu_timing.sv

//--- testbench/ppu_timing_stimulus.txt
# frame line dot  regs: render_en vbl_en bg_clip obj_clip status_rd (read follows the check)
# expected: fetch_nt fetch_at fetch_ta fetch_tb s_ev e_ev clip_b clip_o
#           hblank sync burst picture vblank blnk irq status_d7
0 0   1   11100 1000001000010000
0 0   3   11010 0100000100010000
0 5   5   11000 0010000000010000
0 5   65  11000 1000100000010000
0 5   256 11000 0000010000010000
0 5   280 11000 0000000011010000
0 5   311 11000 0000000010110000
0 5   327 11000 0001000010010000
0 10  105 01000 0000000000010100
0 240 5   11000 0000000000000000
0 241 0   11000 0000000010001100
0 241 1   11000 0000000000001110
0 243 10  00000 0000000000001100
0 245 100 01000 0000000001001110
0 245 310 01001 0000000011001110
0 245 311 01000 0000000011001101
0 261 1   11000 1000000000000001
0 261 329 11000 1000000010000001
1 0   0   11000 0000000010010001
1 241 1   11000 0000000000001111
1 261 0   11000 0000000010000011
1 261 1   11001 1000000000000001
1 261 2   11000 0000000000000000
2 0   0   11000 0000000010010000
3 100 8   00110 0000001100010100
3 100 9   00110 0000000000010100
3 261 340 00000 0000000010000100
4 0   0   00000 0000000010010100

//--- testbench/tb_ppu_timing.sv
// Testbench for the video timing top, replays checkpoint rows from the stimulus file against a position model
module tb_ppu_timing import ppu_timing_pkg::*; ();

	logic   pclk;
	logic   rst_n;
	logic   render_en;
	logic   vbl_en;
	logic   bg_clip;
	logic   obj_clip;
	logic   status_rd;
	h_pos_t h_pos;
	v_pos_t v_pos;
	logic   fetch_nt, fetch_at, fetch_ta, fetch_tb, s_ev, e_ev, clip_b, clip_o;
	logic   hblank, hblank_start, sync, burst, sc_cnt;
	logic   picture, vblank, vsync, blnk, vset, vclr, irq, status_d7;

	int   cnt_dot, cnt_line, cnt_frame;	// Model counters
	int   rep_dot, rep_line, rep_frame;	// Model of the reported position
	logic odd;
	logic line_done;
	int   seed = 85069;
	int   errors = 0;
	int   checks = 0;
	logic timed_out = 1'b0;
	string out_names [16] = '{"fetch_nt", "fetch_at", "fetch_ta", "fetch_tb", "s_ev", "e_ev",
		"clip_b", "clip_o", "hblank", "sync", "burst", "picture", "vblank", "blnk", "irq",
		"status_d7"};

	ppu_timing_top dut (.*);

	always #50 pclk = ~pclk;

	// Odd frames lose the last pre-render dot while rendering
	assign line_done = (cnt_dot == h_total - 1) ||
		(odd && render_en && cnt_line == prerender_line && cnt_dot == h_total - 2);

	always @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_dot   <= 0;
			cnt_line  <= 0;
			cnt_frame <= 0;
			rep_dot   <= 0;
			rep_line  <= 0;
			rep_frame <= 0;
			odd       <= 1'b0;
		end else begin
			rep_dot   <= cnt_dot;
			rep_line  <= cnt_line;
			rep_frame <= cnt_frame;
			cnt_dot   <= line_done ? 0 : cnt_dot + 1;
			if (line_done && cnt_line == v_total - 1) begin
				cnt_line  <= 0;
				cnt_frame <= cnt_frame + 1;
				odd       <= ~odd;
			end else if (line_done) begin
				cnt_line <= cnt_line + 1;
			end
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s expected %0b got %0b", $time, name, exp, got);
		end
	endtask

	task automatic check_pos(input h_pos_t exp_h, input v_pos_t exp_v);
		checks++;
		if (h_pos !== exp_h || v_pos !== exp_v) begin
			errors++;
			$display("mismatch at %0t: h_pos/v_pos expected %0d/%0d got %0d/%0d",
				$time, exp_h, exp_v, h_pos, v_pos);
		end
	endtask

	// Walks to a frame position, with one spot check of the ranges at a random dot on the way
	task automatic wait_for(input int frame, input int line, input int dot);
		int n;
		int gap;
		n = 0;
		gap = 1 + ($random(seed) & 1023);
		while (!(rep_frame == frame && rep_line == line && rep_dot == dot) && n < 200000) begin
			@(negedge pclk);
			status_rd = 1'b0;	// Read strobe lasts one cycle
			n++;
			if (n == gap) begin
				check_pos(h_pos_t'(rep_dot), v_pos_t'(rep_line));
				check_bit("hblank", hblank, rep_dot >= 257 || rep_dot == 0);
				check_bit("picture", picture, rep_line <= 239);
				check_bit("vblank", vblank, rep_line >= 241 && rep_line <= 260);
				check_bit("vsync", vsync, rep_line >= 244 && rep_line <= 246);
			end
		end
		if (!(rep_frame == frame && rep_line == line && rep_dot == dot)) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: frame %0d line %0d dot %0d was never reached", frame, line, dot);
		end
	endtask

	initial begin
		int          fd;
		int          rows;
		int          tgt_frame;
		int          tgt_line;
		int          tgt_dot;
		string       text;
		logic [4:0]  regs;
		logic [15:0] exp_bits;
		logic [15:0] got_bits;

		pclk      = 1'b0;
		rst_n     = 1'b0;
		render_en = 1'b0;
		vbl_en    = 1'b0;
		bg_clip   = 1'b0;
		obj_clip  = 1'b0;
		status_rd = 1'b0;
		rows      = 0;
		repeat (16) @(posedge pclk);
		@(negedge pclk);
		rst_n = 1'b1;

		fd = $fopen("testbench/ppu_timing_stimulus.txt", "r");
		while (fd != 0 && !timed_out && $fgets(text, fd) > 0) begin
			if ($sscanf(text, "%d %d %d %b %b", tgt_frame, tgt_line, tgt_dot, regs,
				exp_bits) == 5) begin
				rows++;
				render_en = regs[4];
				vbl_en    = regs[3];
				bg_clip   = regs[2];
				obj_clip  = regs[1];
				wait_for(tgt_frame, tgt_line, tgt_dot);
				if (!timed_out) begin
					check_pos(h_pos_t'(tgt_dot), v_pos_t'(tgt_line));
					got_bits = {fetch_nt, fetch_at, fetch_ta, fetch_tb, s_ev, e_ev, clip_b,
						clip_o, hblank, sync, burst, picture, vblank, blnk, irq, status_d7};
					for (int i = 0; i < 16; i++) begin
						check_bit(out_names[i], got_bits[15 - i], exp_bits[15 - i]);
					end
					check_bit("vsync", vsync, tgt_line >= 244 && tgt_line <= 246);
					check_bit("sc_cnt", sc_cnt, exp_bits[7] & render_en);
					// Reported dot is the last one of its line
					check_bit("hblank_start", hblank_start, cnt_dot == 0 && rep_dot != 0);
					// Pulses one cycle ahead of the flag edges
					check_bit("vset", vset, tgt_line == 241 && tgt_dot == 0);
					check_bit("vclr", vclr, tgt_line == 261 && tgt_dot == 0);
					status_rd = regs[0];	// CPU read right after the check
				end
			end
		end
		if (rows == 0) begin
			errors++;
			$display("No checkpoint rows could be read from the stimulus file");
		end
		$display("Checks: %0d  Rows: %0d  Errors: %0d", checks, rows, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
